// ==== dv/aduli_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module aduli_tb;
    import calib_pkg::*;

    localparam int NUM_LEDS = 12;
    localparam int NUM_PIXELS = 16;
    localparam int LED_ADDRESS_WIDTH = 4;
    localparam int BIT_CYCLES = 6;
    localparam int T0H_CYCLES = 2;
    localparam int T1H_CYCLES = 4;
    localparam int LATCH_CYCLES = 20;
    localparam int WAIT_LIMIT = 40000;
    localparam logic [23:0] LIT_COLOUR = 24'hff_ffff;
    localparam logic [23:0] DARK_COLOUR = 24'h00_0000;
    // no bit stays low this long, so it marks the latch gap.
    localparam int GAP_DETECT = 2 * BIT_CYCLES;

    logic clk_in = 1'b0;
    logic rst_in = 1'b1;
    logic start = 1'b0;
    logic frame_start = 1'b0;
    logic pixel_valid = 1'b0;
    logic pixel_bright = 1'b0;
    logic [3:0] rd_addr = 4'h0;
    logic led_data;
    aduli_state_t calib_state;
    logic [3:0] rd_data;

    // two words per pixel with the mapped led first.
    logic [3:0] testdata [0:4*NUM_PIXELS-1];
    logic [3:0] cur_map [NUM_PIXELS];
    logic [3:0] expected_code [NUM_PIXELS];
    logic led_lit [NUM_LEDS];
    logic [23:0] colours [NUM_LEDS];
    logic [31:0] rng_state = 32'hc3fc_1df7;

    int value_errors = 0;
    int strip_errors = 0;
    int other_errors = 0;

    int high_cnt = 0;
    int low_cnt = 0;
    int bit_cnt = 0;
    int led_cnt = 0;
    int frames_decoded = 0;
    int frame_base = 0;
    logic prev_level = 1'b0;
    logic [23:0] shift_reg = 24'h0;

    aduli_top #(
        .NUM_LEDS(NUM_LEDS),
        .NUM_PIXELS(NUM_PIXELS),
        .BIT_CYCLES(BIT_CYCLES),
        .T0H_CYCLES(T0H_CYCLES),
        .T1H_CYCLES(T1H_CYCLES),
        .LATCH_CYCLES(LATCH_CYCLES)
    ) aduli_top_i (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .start(start),
        .frame_start(frame_start),
        .pixel_valid(pixel_valid),
        .pixel_bright(pixel_bright),
        .rd_addr(rd_addr),
        .led_data(led_data),
        .calib_state(calib_state),
        .rd_data(rd_data)
    );

    always #50 clk_in = ~clk_in;

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic pixel_sees_light(input int p);
        if (cur_map[p] == 4'hf) begin
            return 1'b0;
        end
        return led_lit[cur_map[p]];
    endfunction

    // after the first step every bit of a code holds the bit 0 brightness.
    function automatic logic [3:0] first_step_code(input int p);
        if ((cur_map[p] != 4'hf) && cur_map[p][0]) begin
            return 4'hf;
        end
        return 4'h0;
    endfunction

    // the high time of each pulse gives the bit.
    always @(negedge clk_in) begin : strip_decoder
        int k;
        logic [23:0] want;
        if (rst_in) begin
            high_cnt = 0;
            low_cnt = 0;
            bit_cnt = 0;
            led_cnt = 0;
            prev_level = 1'b0;
            frames_decoded <= 0;
            for (int i = 0; i < NUM_LEDS; i++) begin
                led_lit[i] <= 1'b0;
            end
        end else if (led_data) begin
            high_cnt = high_cnt + 1;
            low_cnt = 0;
            prev_level = 1'b1;
        end else begin
            if (prev_level) begin
                shift_reg = {shift_reg[22:0], (high_cnt > (T0H_CYCLES + T1H_CYCLES) / 2)};
                high_cnt = 0;
                bit_cnt = bit_cnt + 1;
                if (bit_cnt == 24) begin
                    bit_cnt = 0;
                    if (led_cnt < NUM_LEDS) begin
                        colours[led_cnt] = shift_reg;
                    end
                    led_cnt = led_cnt + 1;
                end
            end
            prev_level = 1'b0;
            low_cnt = low_cnt + 1;
            if ((low_cnt == GAP_DETECT) && ((led_cnt > 0) || (bit_cnt > 0))) begin
                k = frames_decoded - frame_base;
                if ((led_cnt != NUM_LEDS) || (bit_cnt != 0)) begin
                    strip_errors++;
                    $display("Strip frame %0d carried %0d leds and %0d extra bits",
                             k, led_cnt, bit_cnt);
                end
                for (int i = 0; i < NUM_LEDS; i++) begin
                    want = (((i >> k) & 1) == 1) ? LIT_COLOUR : DARK_COLOUR;
                    if (colours[i] != want) begin
                        strip_errors++;
                        $display("Error: led_data colour of led %0d in frame %0d is 0x%06h, expected 0x%06h",
                                 i, k, colours[i], want);
                    end
                    // the strip shows the new colours once the gap is seen.
                    led_lit[i] <= (colours[i] != DARK_COLOUR);
                end
                frames_decoded <= frames_decoded + 1;
                led_cnt = 0;
                bit_cnt = 0;
            end
        end
    end

    // sensor frames run back to back with random pixel gaps.
    initial begin : sensor_model
        int gap;
        forever begin
            @(posedge clk_in);
            frame_start <= 1'b1;
            pixel_valid <= 1'b0;
            for (int p = 0; p < NUM_PIXELS; p++) begin
                gap = int'(next_random() % 32'd4);
                @(posedge clk_in);
                frame_start <= 1'b0;
                pixel_valid <= 1'b0;
                repeat (gap) @(posedge clk_in);
                pixel_valid <= 1'b1;
                pixel_bright <= pixel_sees_light(p);
            end
            gap = int'(next_random() % 32'd4);
            @(posedge clk_in);
            pixel_valid <= 1'b0;
            repeat (gap) @(posedge clk_in);
        end
    end

    task automatic finish_run();
        int total;
        total = value_errors + strip_errors + other_errors;
        $display("Summary: %0d value errors, %0d strip errors, %0d other errors",
                 value_errors, strip_errors, other_errors);
        if (total == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    task automatic wait_for_state(input aduli_state_t want, input string what);
        int cycles;
        cycles = 0;
        while ((calib_state != want) && (cycles < WAIT_LIMIT)) begin
            @(negedge clk_in);
            cycles++;
        end
        if (calib_state != want) begin
            other_errors++;
            $display("Timed out waiting for the sequencer to %s", what);
            finish_run();
        end
    endtask

    task automatic wait_for_frames(input int count);
        int cycles;
        cycles = 0;
        while ((frames_decoded - frame_base < count) && (cycles < WAIT_LIMIT)) begin
            @(negedge clk_in);
            cycles++;
        end
        if (frames_decoded - frame_base < count) begin
            other_errors++;
            $display("Timed out waiting for strip frame %0d of the run", count);
            finish_run();
        end
    endtask

    task automatic pulse_start();
        @(posedge clk_in);
        start <= 1'b1;
        @(posedge clk_in);
        start <= 1'b0;
    endtask

    task automatic check_code(input int p, input logic [3:0] want, input string label);
        @(posedge clk_in);
        rd_addr <= 4'(p);
        @(posedge clk_in);
        @(negedge clk_in);
        if (rd_data !== want) begin
            value_errors++;
            $display("Error: rd_data for pixel %0d %s is 0x%h, expected 0x%h",
                     p, label, rd_data, want);
        end
    endtask

    task automatic read_back_codes(input int run);
        for (int p = 0; p < NUM_PIXELS; p++) begin
            check_code(p, expected_code[p], $sformatf("after run %0d", run));
        end
    endtask

    task automatic run_calibration(input int run, input logic poke);
        for (int p = 0; p < NUM_PIXELS; p++) begin
            cur_map[p] = testdata[2 * (run * NUM_PIXELS + p)];
            expected_code[p] = testdata[2 * (run * NUM_PIXELS + p) + 1];
        end
        frame_base = frames_decoded;
        pulse_start();
        wait_for_state(SHOW_CALIB_LED, "leave DISPLAY");
        wait_for_state(RUN_CALIB_STEP, "start the first capture step");
        wait_for_state(SHOW_CALIB_LED, "show the second frame");
        // codes are stable while the second frame goes out.
        for (int p = 0; p < NUM_PIXELS; p++) begin
            check_code(p, first_step_code(p),
                       $sformatf("after the first step of run %0d", run));
        end
        if (poke) begin
            // start in the middle of a run is ignored.
            wait_for_frames(2);
            pulse_start();
        end
        wait_for_state(DISPLAY, "return to DISPLAY");
        if (frames_decoded - frame_base != LED_ADDRESS_WIDTH) begin
            other_errors++;
            $display("Run %0d showed %0d strip frames instead of %0d",
                     run, frames_decoded - frame_base, LED_ADDRESS_WIDTH);
        end
        read_back_codes(run);
    endtask

    initial begin : main_sequence
        $readmemh("dv/aduli_testdata.mem", testdata);
        for (int p = 0; p < NUM_PIXELS; p++) begin
            cur_map[p] = 4'hf;
        end
        repeat (8) @(posedge clk_in);
        rst_in <= 1'b0;
        @(negedge clk_in);
        if (calib_state != DISPLAY) begin
            value_errors++;
            $display("Error: calib_state after reset is 0x%h, expected 0x%h",
                     calib_state, DISPLAY);
        end
        if (led_data !== 1'b0) begin
            value_errors++;
            $display("Error: led_data after reset is 0x%h, expected 0x0", led_data);
        end
        run_calibration(0, 1'b1);
        // the second map moves and darkens pixels, so old codes must go.
        run_calibration(1, 1'b0);
        finish_run();
    end

endmodule

`default_nettype wire

// ==== dv/aduli_testdata.mem ====
// columns: mapped led index (f = sees no led), expected code; both hex
// lines 0 to 15 are pixels 0 to 15 of run 0, the next 16 lines are run 1
0 0
1 1
2 2
3 3
4 4
5 5
6 6
7 7
8 8
9 9
a a
b b
f 0
5 5
f 0
3 3
b b
f 0
9 9
8 8
7 7
6 6
f 0
4 4
3 3
2 2
1 1
0 0
a a
f 0
5 5
2 2

// ==== list.f ====
logic/calib_pkg.sv
logic/led_strip_pkg.sv
logic/aduli_fsm.sv
logic/led_frame_tx.sv
logic/calibration_step_fsm.sv
logic/pixel_code_ram.sv
logic/aduli_top.sv
dv/aduli_tb.sv

// ==== logic/aduli_fsm.sv ====
`timescale 1ns/1ns
`default_nettype none

module aduli_fsm #(
    parameter int LED_ADDRESS_WIDTH = 6,
    parameter int LED_ADDR_BIT_SEL_WIDTH =
        (LED_ADDRESS_WIDTH > 1) ? $clog2(LED_ADDRESS_WIDTH) : 1
) (
    input wire clk_in,
    input wire rst_in,

    input wire start,

    input wire led_display_valid,
    input wire calib_pkg::calibration_step_state_t calibration_state,
    output logic [LED_ADDR_BIT_SEL_WIDTH-1:0] led_addr_bit_sel,
    output logic led_addr_bit_sel_start,
    output logic calibration_start,
    output logic calibration_first,

    output calib_pkg::aduli_state_t state
);
    import calib_pkg::*;

    // set once the step has left IDLE for the current bit.
    logic calibration_started;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= DISPLAY;
            led_addr_bit_sel <= '0;
            led_addr_bit_sel_start <= 1'b0;
            calibration_start <= 1'b0;
            calibration_first <= 1'b0;
            calibration_started <= 1'b0;
        end else begin
            led_addr_bit_sel_start <= 1'b0;
            calibration_start <= 1'b0;
            case (state)
                DISPLAY: begin
                    if (start) begin
                        led_addr_bit_sel <= '0;
                        led_addr_bit_sel_start <= 1'b1;
                        calibration_first <= 1'b1;
                        state <= SHOW_CALIB_LED;
                    end
                end
                SHOW_CALIB_LED: begin
                    if (led_display_valid) begin
                        calibration_start <= 1'b1;
                        calibration_started <= 1'b0;
                        state <= RUN_CALIB_STEP;
                    end
                end
                RUN_CALIB_STEP: begin
                    if (calibration_state != IDLE) begin
                        calibration_started <= 1'b1;
                    end
                    if ((calibration_state == IDLE) && calibration_started) begin
                        calibration_started <= 1'b0;
                        // first stays up for the whole first step.
                        calibration_first <= 1'b0;
                        if (int'(led_addr_bit_sel) == LED_ADDRESS_WIDTH - 1) begin
                            state <= DISPLAY;
                        end else begin
                            led_addr_bit_sel <= led_addr_bit_sel + 1'b1;
                            led_addr_bit_sel_start <= 1'b1;
                            state <= SHOW_CALIB_LED;
                        end
                    end
                end
                default: begin
                    state <= DISPLAY;
                end
            endcase
        end
    end

    no_step_in_display: assert property (
        @(posedge clk_in) disable iff (rst_in)
        !(calibration_start && (state == DISPLAY))
    );

endmodule

`default_nettype wire

// ==== logic/aduli_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module aduli_top #(
    parameter int NUM_LEDS = 50,
    parameter int NUM_PIXELS = 64,
    parameter int LED_ADDRESS_WIDTH = $clog2(NUM_LEDS),
    parameter int LED_ADDR_BIT_SEL_WIDTH =
        (LED_ADDRESS_WIDTH > 1) ? $clog2(LED_ADDRESS_WIDTH) : 1,
    parameter int PIXEL_ADDR_WIDTH = (NUM_PIXELS > 1) ? $clog2(NUM_PIXELS) : 1,
    // ws2812 timing at 100 mhz.
    parameter int BIT_CYCLES = 125,
    parameter int T0H_CYCLES = 40,
    parameter int T1H_CYCLES = 80,
    parameter int LATCH_CYCLES = 6000
) (
    input wire clk_in,
    input wire rst_in,

    input wire start,

    input wire frame_start,
    input wire pixel_valid,
    input wire pixel_bright,

    input wire [PIXEL_ADDR_WIDTH-1:0] rd_addr,

    output logic led_data,
    output calib_pkg::aduli_state_t calib_state,
    output logic [LED_ADDRESS_WIDTH-1:0] rd_data
);
    import calib_pkg::*;

    logic [LED_ADDR_BIT_SEL_WIDTH-1:0] led_addr_bit_sel;
    logic led_addr_bit_sel_start;
    logic led_display_valid;
    logic calibration_start;
    logic calibration_first;
    calibration_step_state_t calibration_state;
    logic wr_en;
    logic [PIXEL_ADDR_WIDTH-1:0] wr_addr;
    logic [LED_ADDRESS_WIDTH-1:0] wr_mask;
    logic [LED_ADDRESS_WIDTH-1:0] wr_data;

    aduli_fsm #(
        .LED_ADDRESS_WIDTH(LED_ADDRESS_WIDTH),
        .LED_ADDR_BIT_SEL_WIDTH(LED_ADDR_BIT_SEL_WIDTH)
    ) aduli_fsm_i (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .start(start),
        .led_display_valid(led_display_valid),
        .calibration_state(calibration_state),
        .led_addr_bit_sel(led_addr_bit_sel),
        .led_addr_bit_sel_start(led_addr_bit_sel_start),
        .calibration_start(calibration_start),
        .calibration_first(calibration_first),
        .state(calib_state)
    );

    led_frame_tx #(
        .NUM_LEDS(NUM_LEDS),
        .LED_ADDRESS_WIDTH(LED_ADDRESS_WIDTH),
        .LED_ADDR_BIT_SEL_WIDTH(LED_ADDR_BIT_SEL_WIDTH),
        .BIT_CYCLES(BIT_CYCLES),
        .T0H_CYCLES(T0H_CYCLES),
        .T1H_CYCLES(T1H_CYCLES),
        .LATCH_CYCLES(LATCH_CYCLES)
    ) led_frame_tx_i (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .led_addr_bit_sel(led_addr_bit_sel),
        .led_addr_bit_sel_start(led_addr_bit_sel_start),
        .led_data(led_data),
        .led_display_valid(led_display_valid)
    );

    calibration_step_fsm #(
        .NUM_PIXELS(NUM_PIXELS),
        .LED_ADDRESS_WIDTH(LED_ADDRESS_WIDTH),
        .LED_ADDR_BIT_SEL_WIDTH(LED_ADDR_BIT_SEL_WIDTH),
        .PIXEL_ADDR_WIDTH(PIXEL_ADDR_WIDTH)
    ) calibration_step_fsm_i (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .calibration_start(calibration_start),
        .calibration_first(calibration_first),
        .led_addr_bit_sel(led_addr_bit_sel),
        .frame_start(frame_start),
        .pixel_valid(pixel_valid),
        .pixel_bright(pixel_bright),
        .state(calibration_state),
        .wr_en(wr_en),
        .wr_addr(wr_addr),
        .wr_mask(wr_mask),
        .wr_data(wr_data)
    );

    pixel_code_ram #(
        .NUM_PIXELS(NUM_PIXELS),
        .LED_ADDRESS_WIDTH(LED_ADDRESS_WIDTH),
        .PIXEL_ADDR_WIDTH(PIXEL_ADDR_WIDTH)
    ) pixel_code_ram_i (
        .clk_in(clk_in),
        .wr_en(wr_en),
        .wr_addr(wr_addr),
        .wr_mask(wr_mask),
        .wr_data(wr_data),
        .rd_addr(rd_addr),
        .rd_data(rd_data)
    );

endmodule

`default_nettype wire

// ==== logic/calib_pkg.sv ====
`default_nettype none

package calib_pkg;

    // top level sequencer.
    typedef enum logic [1:0] {
        DISPLAY        = 2'd0,
        SHOW_CALIB_LED = 2'd1,
        RUN_CALIB_STEP = 2'd2
    } aduli_state_t;

    // one sensor frame capture.
    typedef enum logic [1:0] {
        IDLE       = 2'd0,
        WAIT_FRAME = 2'd1,
        CAPTURE    = 2'd2
    } calibration_step_state_t;

endpackage

`default_nettype wire

// ==== logic/calibration_step_fsm.sv ====
`timescale 1ns/1ns
`default_nettype none

module calibration_step_fsm #(
    parameter int NUM_PIXELS = 64,
    parameter int LED_ADDRESS_WIDTH = 6,
    parameter int LED_ADDR_BIT_SEL_WIDTH =
        (LED_ADDRESS_WIDTH > 1) ? $clog2(LED_ADDRESS_WIDTH) : 1,
    parameter int PIXEL_ADDR_WIDTH = (NUM_PIXELS > 1) ? $clog2(NUM_PIXELS) : 1
) (
    input wire clk_in,
    input wire rst_in,

    input wire calibration_start,
    input wire calibration_first,
    input wire [LED_ADDR_BIT_SEL_WIDTH-1:0] led_addr_bit_sel,

    input wire frame_start,
    input wire pixel_valid,
    input wire pixel_bright,

    output calib_pkg::calibration_step_state_t state,

    output logic wr_en,
    output logic [PIXEL_ADDR_WIDTH-1:0] wr_addr,
    output logic [LED_ADDRESS_WIDTH-1:0] wr_mask,
    output logic [LED_ADDRESS_WIDTH-1:0] wr_data
);
    import calib_pkg::*;

    logic [PIXEL_ADDR_WIDTH-1:0] pixel_cnt;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= IDLE;
            pixel_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (calibration_start) begin
                        state <= WAIT_FRAME;
                    end
                end
                WAIT_FRAME: begin
                    // a frame already running is skipped.
                    if (frame_start) begin
                        pixel_cnt <= '0;
                        state <= CAPTURE;
                    end
                end
                CAPTURE: begin
                    if (pixel_valid) begin
                        pixel_cnt <= pixel_cnt + 1'b1;
                        if (int'(pixel_cnt) == NUM_PIXELS - 1) begin
                            state <= IDLE;
                        end
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // the first step rewrites the whole code, later ones only bit k.
    assign wr_en = (state == CAPTURE) && pixel_valid;
    assign wr_addr = pixel_cnt;
    assign wr_mask = calibration_first ? '1 : (LED_ADDRESS_WIDTH'(1) << led_addr_bit_sel);
    assign wr_data = {LED_ADDRESS_WIDTH{pixel_bright}};

    no_frame_start_in_capture: assert property (
        @(posedge clk_in) disable iff (rst_in)
        (state == CAPTURE) |-> !frame_start
    );

endmodule

`default_nettype wire

// ==== logic/led_frame_tx.sv ====
`timescale 1ns/1ns
`default_nettype none

module led_frame_tx #(
    parameter int NUM_LEDS = 50,
    parameter int LED_ADDRESS_WIDTH = $clog2(NUM_LEDS),
    parameter int LED_ADDR_BIT_SEL_WIDTH =
        (LED_ADDRESS_WIDTH > 1) ? $clog2(LED_ADDRESS_WIDTH) : 1,
    parameter int BIT_CYCLES = 125,
    parameter int T0H_CYCLES = 40,
    parameter int T1H_CYCLES = 80,
    parameter int LATCH_CYCLES = 6000
) (
    input wire clk_in,
    input wire rst_in,

    input wire [LED_ADDR_BIT_SEL_WIDTH-1:0] led_addr_bit_sel,
    input wire led_addr_bit_sel_start,

    output logic led_data,
    output logic led_display_valid
);
    import led_strip_pkg::*;

    localparam int COLOR_BITS = $bits(rgb_t);
    localparam int COLOR_BIT_WIDTH = $clog2(COLOR_BITS);
    localparam int PHASE_WIDTH = (BIT_CYCLES > 1) ? $clog2(BIT_CYCLES) : 1;
    localparam int LATCH_WIDTH = (LATCH_CYCLES > 1) ? $clog2(LATCH_CYCLES) : 1;

    logic [LED_ADDR_BIT_SEL_WIDTH-1:0] bit_sel;
    logic sending;
    logic latching;
    logic [LED_ADDRESS_WIDTH-1:0] led_idx;
    logic [LED_ADDRESS_WIDTH-1:0] led_idx_next;
    logic [COLOR_BIT_WIDTH-1:0] color_bit;
    logic [COLOR_BIT_WIDTH-1:0] color_bit_next;
    logic [PHASE_WIDTH-1:0] phase;
    logic [PHASE_WIDTH-1:0] phase_next;
    logic last_slot;
    logic [LATCH_WIDTH-1:0] latch_cnt;

    // line level for one clock slot of the frame.
    function automatic logic slot_level(
        input logic [LED_ADDRESS_WIDTH-1:0] idx,
        input logic [COLOR_BIT_WIDTH-1:0] cbit,
        input logic [PHASE_WIDTH-1:0] ph,
        input logic [LED_ADDR_BIT_SEL_WIDTH-1:0] sel
    );
        rgb_t color;
        logic value;
        color = idx[sel] ? CALIB_ON_COLOR : CALIB_OFF_COLOR;
        value = color[COLOR_BITS - 1 - int'(cbit)];
        if (value) begin
            return int'(ph) < T1H_CYCLES;
        end
        return int'(ph) < T0H_CYCLES;
    endfunction

    // position of the slot after the current one.
    always_comb begin
        phase_next = phase + 1'b1;
        color_bit_next = color_bit;
        led_idx_next = led_idx;
        last_slot = 1'b0;
        if (int'(phase) == BIT_CYCLES - 1) begin
            phase_next = '0;
            if (int'(color_bit) == COLOR_BITS - 1) begin
                color_bit_next = '0;
                if (int'(led_idx) == NUM_LEDS - 1) begin
                    last_slot = 1'b1;
                end else begin
                    led_idx_next = led_idx + 1'b1;
                end
            end else begin
                color_bit_next = color_bit + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            sending <= 1'b0;
            latching <= 1'b0;
            led_data <= 1'b0;
            led_display_valid <= 1'b0;
        end else begin
            led_display_valid <= 1'b0;
            if (led_addr_bit_sel_start) begin
                bit_sel <= led_addr_bit_sel;
                led_idx <= '0;
                color_bit <= '0;
                phase <= '0;
                sending <= 1'b1;
                latching <= 1'b0;
                led_data <= slot_level('0, '0, '0, led_addr_bit_sel);
            end else if (sending) begin
                if (last_slot) begin
                    sending <= 1'b0;
                    latching <= 1'b1;
                    latch_cnt <= '0;
                    led_data <= 1'b0;
                end else begin
                    led_idx <= led_idx_next;
                    color_bit <= color_bit_next;
                    phase <= phase_next;
                    led_data <= slot_level(led_idx_next, color_bit_next, phase_next, bit_sel);
                end
            end else if (latching) begin
                // strip latches its colours during this low gap.
                if (int'(latch_cnt) == LATCH_CYCLES - 1) begin
                    latching <= 1'b0;
                    led_display_valid <= 1'b1;
                end else begin
                    latch_cnt <= latch_cnt + 1'b1;
                end
            end
        end
    end

    start_outside_frame: assert property (
        @(posedge clk_in) disable iff (rst_in)
        led_addr_bit_sel_start |-> !(sending || latching)
    );

endmodule

`default_nettype wire

// ==== logic/led_strip_pkg.sv ====
`default_nettype none

package led_strip_pkg;

    // field order matches the wire order, green goes out first.
    typedef struct packed {
        logic [7:0] green;
        logic [7:0] red;
        logic [7:0] blue;
    } rgb_t;

    // lit led during calibration.
    localparam rgb_t CALIB_ON_COLOR = '{
        green: 8'hff,
        red:   8'hff,
        blue:  8'hff
    };

    // dark led during calibration.
    localparam rgb_t CALIB_OFF_COLOR = '{
        green: 8'h00,
        red:   8'h00,
        blue:  8'h00
    };

endpackage

`default_nettype wire

// ==== logic/pixel_code_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module pixel_code_ram #(
    parameter int NUM_PIXELS = 64,
    parameter int LED_ADDRESS_WIDTH = 6,
    parameter int PIXEL_ADDR_WIDTH = (NUM_PIXELS > 1) ? $clog2(NUM_PIXELS) : 1
) (
    input wire clk_in,

    input wire wr_en,
    input wire [PIXEL_ADDR_WIDTH-1:0] wr_addr,
    input wire [LED_ADDRESS_WIDTH-1:0] wr_mask,
    input wire [LED_ADDRESS_WIDTH-1:0] wr_data,

    input wire [PIXEL_ADDR_WIDTH-1:0] rd_addr,
    output logic [LED_ADDRESS_WIDTH-1:0] rd_data
);

    logic [LED_ADDRESS_WIDTH-1:0] mem [NUM_PIXELS];

    always_ff @(posedge clk_in) begin
        if (wr_en) begin
            mem[wr_addr] <= (mem[wr_addr] & ~wr_mask) | (wr_data & wr_mask);
        end
        rd_data <= mem[rd_addr];
    end

    wr_addr_in_range: assert property (
        @(posedge clk_in)
        wr_en |-> (int'(wr_addr) < NUM_PIXELS)
    );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module aduli_tb -f list.f -o aduli_sim

output="$(./obj_dir/aduli_sim)"
echo "$output"

if grep -qx "All checks passed" <<< "$output"; then
    exit 0
fi
exit 1
